// File: hdl/soc_pkg.sv
// address map, bus widths, display and keyboard constants for the peripheral side
`default_nettype none

package soc_pkg;

    // wishbone port widths
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    // word offset bit inside a peripheral
    localparam int WORD_OFS_BIT = 2;

    // register map, word aligned
    localparam logic [ADDR_W-1:0] ADDR_LED     = 8'h00;
    localparam logic [ADDR_W-1:0] ADDR_SWT     = 8'h04;
    localparam logic [ADDR_W-1:0] ADDR_SEG     = 8'h08;
    localparam logic [ADDR_W-1:0] ADDR_KB_DATA = 8'h0C;
    localparam logic [ADDR_W-1:0] ADDR_KB_STAT = 8'h10;

    // board io sizes
    localparam int LED_W = 7;
    localparam int SWT_W = 8;

    // serial display, one active-low segment byte per hex digit
    localparam int SEG_DIGITS  = 8;
    localparam int SEG_FRAME_W = 64;
    localparam int SEG_CNT_W   = $clog2(SEG_FRAME_W);
    // shift clock toggles every 2**SEG_DIV_BIT system clocks
    localparam int SEG_DIV_BIT = 2;

    // ps2 receiver
    localparam int KB_FRAME_W    = 11;
    localparam int KB_BYTE_W     = 8;
    localparam int KB_FIFO_DEPTH = 8;
    localparam int KB_PTR_W      = $clog2(KB_FIFO_DEPTH);
    localparam int KB_CNT_W      = $clog2(KB_FIFO_DEPTH + 1);
    // ready flag position in the data word
    localparam int KB_READY_BIT  = 8;
    // overflow flag in the status word, count sits below it
    localparam int KB_OVF_BIT    = 4;

endpackage

`default_nettype wire

// File: hdl/periph_bus_if.sv
// wishbone classic interface between address decoder and peripherals
`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if import soc_pkg::*; ();

    // request side, driven by the decoder
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat_w;

    // response side, driven by the peripheral
    logic [DATA_W-1:0] dat_r;
    logic              ack;

    // decoder end
    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    // peripheral end
    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

`default_nettype wire

// File: hdl/periph_decoder.sv
// address decoder splitting the wishbone port into gpio, display and keyboard buses
`timescale 1ns/1ps
`default_nettype none

module periph_decoder import soc_pkg::*; (
    input  wire logic              clk200m,
    input  wire logic              rst,
    input  wire logic              wb_cyc,
    input  wire logic              wb_stb,
    input  wire logic              wb_we,
    input  wire logic [ADDR_W-1:0] wb_adr,
    input  wire logic [DATA_W-1:0] wb_dat_w,
    output      logic [DATA_W-1:0] wb_dat_r,
    output      logic              wb_ack,
    periph_bus_if.master           gpio_bus,
    periph_bus_if.master           seg_bus,
    periph_bus_if.master           kb_bus
);

    logic [ADDR_W-1:WORD_OFS_BIT] word_idx;
    logic sel_gpio;
    logic sel_seg;
    logic sel_kb;
    logic sel_none;
    logic unm_ack_q;

    // compare word index only, byte lanes ignored
    assign word_idx = wb_adr[ADDR_W-1:WORD_OFS_BIT];
    assign sel_gpio = (word_idx == ADDR_LED[ADDR_W-1:WORD_OFS_BIT])
                   || (word_idx == ADDR_SWT[ADDR_W-1:WORD_OFS_BIT]);
    assign sel_seg  = (word_idx == ADDR_SEG[ADDR_W-1:WORD_OFS_BIT]);
    assign sel_kb   = (word_idx == ADDR_KB_DATA[ADDR_W-1:WORD_OFS_BIT])
                   || (word_idx == ADDR_KB_STAT[ADDR_W-1:WORD_OFS_BIT]);
    assign sel_none = !(sel_gpio || sel_seg || sel_kb);

    // shared request lines, strobe routed by address
    assign gpio_bus.cyc   = wb_cyc;
    assign gpio_bus.we    = wb_we;
    assign gpio_bus.adr   = wb_adr;
    assign gpio_bus.dat_w = wb_dat_w;
    assign gpio_bus.stb   = wb_stb && sel_gpio;

    assign seg_bus.cyc    = wb_cyc;
    assign seg_bus.we     = wb_we;
    assign seg_bus.adr    = wb_adr;
    assign seg_bus.dat_w  = wb_dat_w;
    assign seg_bus.stb    = wb_stb && sel_seg;

    assign kb_bus.cyc     = wb_cyc;
    assign kb_bus.we      = wb_we;
    assign kb_bus.adr     = wb_adr;
    assign kb_bus.dat_w   = wb_dat_w;
    assign kb_bus.stb     = wb_stb && sel_kb;

    // unmapped access still gets a one-cycle ack
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            unm_ack_q <= 1'b0;
        end else begin
            unm_ack_q <= wb_cyc && wb_stb && sel_none && !unm_ack_q;
        end
    end

    // response mux, address is held until ack
    always_comb begin
        if (sel_gpio) begin
            wb_dat_r = gpio_bus.dat_r;
            wb_ack   = gpio_bus.ack;
        end else if (sel_seg) begin
            wb_dat_r = seg_bus.dat_r;
            wb_ack   = seg_bus.ack;
        end else if (sel_kb) begin
            wb_dat_r = kb_bus.dat_r;
            wb_ack   = kb_bus.ack;
        end else begin
            // zero data for holes in the map
            wb_dat_r = '0;
            wb_ack   = unm_ack_q;
        end
    end

endmodule

`default_nettype wire

// File: hdl/gpio_regs.sv
// led register and switch synchronizer behind a wishbone slave
`timescale 1ns/1ps
`default_nettype none

module gpio_regs import soc_pkg::*; (
    input  wire logic             clk200m,
    input  wire logic             rst,
    periph_bus_if.slave           bus,
    input  wire logic [SWT_W-1:0] swt,
    output      logic [LED_W-1:0] led
);

    logic [LED_W-1:0] led_q;
    logic [SWT_W-1:0] swt_meta_q;
    logic [SWT_W-1:0] swt_sync_q;
    logic             ack_q;
    logic             sel_swt;

    // offset bit picks led or switch word
    assign sel_swt = (bus.adr[WORD_OFS_BIT] == ADDR_SWT[WORD_OFS_BIT]);

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            ack_q <= 1'b0;
            led_q <= '0;
        end else begin
            // ack one cycle after strobe, single cycle wide
            ack_q <= bus.cyc && bus.stb && !ack_q;
            // write lands at the end of the ack cycle
            if (ack_q && bus.we && !sel_swt) begin
                led_q <= bus.dat_w[LED_W-1:0];
            end
        end
    end

    // two-flop switch synchronizer
    always_ff @(posedge clk200m) begin
        swt_meta_q <= swt;
        swt_sync_q <= swt_meta_q;
    end

    always_comb begin
        bus.dat_r = '0;
        if (ack_q) begin
            if (sel_swt) begin
                bus.dat_r = {{(DATA_W-SWT_W){1'b0}}, swt_sync_q};
            end else begin
                bus.dat_r = {{(DATA_W-LED_W){1'b0}}, led_q};
            end
        end
    end

    assign bus.ack = ack_q;
    assign led     = led_q;

endmodule

`default_nettype wire

// File: hdl/seg_serial.sv
// seven-segment serial driver with number register, shift-clock divider and frame shifter
`timescale 1ns/1ps
`default_nettype none

module seg_serial import soc_pkg::*; (
    input  wire logic clk200m,
    input  wire logic rst,
    periph_bus_if.slave bus,
    output      logic seg_clk,
    output      logic seg_clr,
    output      logic seg_dt,
    output      logic seg_en
);

    logic [DATA_W-1:0]      num_q;
    logic                   pend_q;
    logic                   ack_q;
    logic [SEG_DIV_BIT-1:0] div_q;
    logic                   ph_q;
    logic                   busy_q;
    logic [SEG_CNT_W-1:0]   bit_cnt_q;
    logic [SEG_FRAME_W-1:0] shift_q;
    logic [SEG_FRAME_W-1:0] frame;
    logic                   seg_clk_q;
    logic                   seg_en_q;
    logic                   seg_clr_q;
    logic                   tick;
    logic                   load;
    logic                   wr;

    // hex digit to active-low segments, bit 7 is the dot
    function automatic logic [7:0] hex_to_seg(input logic [3:0] hex);
        logic [7:0] seg;
        case (hex)
            4'h0: seg = 8'hC0;
            4'h1: seg = 8'hF9;
            4'h2: seg = 8'hA4;
            4'h3: seg = 8'hB0;
            4'h4: seg = 8'h99;
            4'h5: seg = 8'h92;
            4'h6: seg = 8'h82;
            4'h7: seg = 8'hF8;
            4'h8: seg = 8'h80;
            4'h9: seg = 8'h90;
            4'hA: seg = 8'h88;
            4'hB: seg = 8'h83;
            4'hC: seg = 8'hC6;
            4'hD: seg = 8'hA1;
            4'hE: seg = 8'h86;
            default: seg = 8'h8E;
        endcase
        return seg;
    endfunction

    // most significant digit ends up in the top byte and goes out first
    always_comb begin
        for (int d = 0; d < SEG_DIGITS; d++) begin
            frame[d*8 +: 8] = hex_to_seg(num_q[d*4 +: 4]);
        end
    end

    assign wr   = ack_q && bus.we;
    assign tick = &div_q;
    // start only at the beginning of a low phase
    assign load = tick && ph_q && !busy_q && pend_q;

    // bus side, number register and pending flag
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            ack_q  <= 1'b0;
            num_q  <= '0;
            pend_q <= 1'b0;
        end else begin
            ack_q <= bus.cyc && bus.stb && !ack_q;
            if (wr) begin
                num_q  <= bus.dat_w;
                pend_q <= 1'b1;
            end else if (load) begin
                pend_q <= 1'b0;
            end
        end
    end

    // free-running divider and the shifter
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            div_q     <= '0;
            ph_q      <= 1'b0;
            busy_q    <= 1'b0;
            bit_cnt_q <= '0;
            shift_q   <= '0;
            seg_clk_q <= 1'b0;
            seg_en_q  <= 1'b0;
            seg_clr_q <= 1'b0;
        end else begin
            seg_clr_q <= 1'b1;
            div_q     <= div_q + 1'b1;
            if (tick) begin
                ph_q <= !ph_q;
                if (!ph_q) begin
                    // rising edge, receiver samples here
                    seg_clk_q <= busy_q;
                end else begin
                    // low phase, data may change
                    seg_clk_q <= 1'b0;
                    if (busy_q) begin
                        if (bit_cnt_q == SEG_CNT_W'(SEG_FRAME_W - 1)) begin
                            busy_q   <= 1'b0;
                            seg_en_q <= 1'b1;
                        end else begin
                            shift_q   <= {shift_q[SEG_FRAME_W-2:0], 1'b0};
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end else if (load) begin
                        shift_q   <= frame;
                        bit_cnt_q <= '0;
                        busy_q    <= 1'b1;
                        seg_en_q  <= 1'b0;
                    end
                end
            end
        end
    end

    assign bus.dat_r = ack_q ? num_q : '0;
    assign bus.ack   = ack_q;
    assign seg_clk   = seg_clk_q;
    assign seg_clr   = seg_clr_q;
    assign seg_dt    = shift_q[SEG_FRAME_W-1];
    assign seg_en    = seg_en_q;

endmodule

`default_nettype wire

// File: hdl/ps2_kbd_rx.sv
// ps2 keyboard receiver with line synchronizer, frame check, byte fifo and status register
`timescale 1ns/1ps
`default_nettype none

module ps2_kbd_rx import soc_pkg::*; (
    input  wire logic clk200m,
    input  wire logic rst,
    periph_bus_if.slave bus,
    input  wire logic ps2_clk,
    input  wire logic ps2_data
);

    logic [2:0]            clk_sync_q;
    logic [1:0]            dat_sync_q;
    logic                  ps2_fall;
    logic                  ps2_dat_s;
    logic [3:0]            bit_cnt_q;
    logic [KB_FRAME_W-1:0] frame_q;
    logic                  done_q;
    logic                  frame_ok;
    logic                  push;
    logic                  pop;
    logic                  stat_rd;
    logic                  sel_data;
    logic                  ack_q;
    logic                  ovf_q;
    logic [KB_BYTE_W-1:0]  mem [KB_FIFO_DEPTH];
    logic [KB_PTR_W-1:0]   wptr_q;
    logic [KB_PTR_W-1:0]   rptr_q;
    logic [KB_CNT_W-1:0]   count_q;
    logic                  full;
    logic                  empty;

    // lines idle high, two flops each plus one for edge detect
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            clk_sync_q <= '1;
            dat_sync_q <= '1;
        end else begin
            clk_sync_q <= {clk_sync_q[1:0], ps2_clk};
            dat_sync_q <= {dat_sync_q[0], ps2_data};
        end
    end

    assign ps2_fall  = clk_sync_q[2] && !clk_sync_q[1];
    assign ps2_dat_s = dat_sync_q[1];

    // frame assembly, lsb first, a high line at bit 0 is no start bit
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            bit_cnt_q <= '0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (ps2_fall && (bit_cnt_q != '0 || !ps2_dat_s)) begin
                if (bit_cnt_q == 4'(KB_FRAME_W - 1)) begin
                    bit_cnt_q <= '0;
                    done_q    <= 1'b1;
                end else begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk200m) begin
        if (ps2_fall && (bit_cnt_q != '0 || !ps2_dat_s)) begin
            frame_q <= {ps2_dat_s, frame_q[KB_FRAME_W-1:1]};
        end
    end

    // start low, odd parity over data and parity bit, stop high
    assign frame_ok = !frame_q[0] && (^frame_q[9:1]) && frame_q[10];
    assign push     = done_q && frame_ok;

    // bus decode on the offset bit only
    assign sel_data = (bus.adr[WORD_OFS_BIT] == ADDR_KB_DATA[WORD_OFS_BIT]);
    assign full     = (count_q == KB_CNT_W'(KB_FIFO_DEPTH));
    assign empty    = (count_q == '0);
    assign pop      = ack_q && !bus.we && sel_data && !empty;
    assign stat_rd  = ack_q && !bus.we && !sel_data;

    // fifo pointers, count and sticky overflow
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            ack_q   <= 1'b0;
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
            ovf_q   <= 1'b0;
        end else begin
            ack_q <= bus.cyc && bus.stb && !ack_q;
            if (push && !full) begin
                wptr_q <= wptr_q + 1'b1;
            end
            if (pop) begin
                rptr_q <= rptr_q + 1'b1;
            end
            if ((push && !full) && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (!(push && !full) && pop) begin
                count_q <= count_q - 1'b1;
            end
            // a new overflow wins over the clearing read
            if (push && full) begin
                ovf_q <= 1'b1;
            end else if (stat_rd) begin
                ovf_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk200m) begin
        if (push && !full) begin
            mem[wptr_q] <= frame_q[8:1];
        end
    end

    // read word, zero outside the ack cycle
    always_comb begin
        bus.dat_r = '0;
        if (ack_q) begin
            if (sel_data) begin
                if (!empty) begin
                    bus.dat_r[KB_BYTE_W-1:0] = mem[rptr_q];
                    bus.dat_r[KB_READY_BIT]  = 1'b1;
                end
            end else begin
                bus.dat_r[KB_CNT_W-1:0] = count_q;
                bus.dat_r[KB_OVF_BIT]   = ovf_q;
            end
        end
    end

    assign bus.ack = ack_q;

endmodule

`default_nettype wire

// File: hdl/periph_top.sv
// peripheral top level with wishbone port, decoder, gpio, display and keyboard
`timescale 1ns/1ps
`default_nettype none

module periph_top import soc_pkg::*; (
    input  wire logic              clk200m,
    input  wire logic              rst,
    // wishbone classic slave port
    input  wire logic              wb_cyc,
    input  wire logic              wb_stb,
    input  wire logic              wb_we,
    input  wire logic [ADDR_W-1:0] wb_adr,
    input  wire logic [DATA_W-1:0] wb_dat_w,
    output      logic [DATA_W-1:0] wb_dat_r,
    output      logic              wb_ack,
    // board io
    input  wire logic              ps2_clk,
    input  wire logic              ps2_data,
    input  wire logic [SWT_W-1:0]  swt,
    output      logic [7:0]        leds,
    output      logic              seg_clk,
    output      logic              seg_clr,
    output      logic              seg_dt,
    output      logic              seg_en
);

    logic [LED_W-1:0] led;

    // one bus per peripheral
    periph_bus_if gpio_bus ();
    periph_bus_if seg_bus ();
    periph_bus_if kb_bus ();

    periph_decoder periph_decoder_inst (
        .clk200m  (clk200m),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .gpio_bus (gpio_bus.master),
        .seg_bus  (seg_bus.master),
        .kb_bus   (kb_bus.master)
    );

    gpio_regs gpio_regs_inst (
        .clk200m (clk200m),
        .rst     (rst),
        .bus     (gpio_bus.slave),
        .swt     (swt),
        .led     (led)
    );

    seg_serial seg_serial_inst (
        .clk200m (clk200m),
        .rst     (rst),
        .bus     (seg_bus.slave),
        .seg_clk (seg_clk),
        .seg_clr (seg_clr),
        .seg_dt  (seg_dt),
        .seg_en  (seg_en)
    );

    ps2_kbd_rx ps2_kbd_rx_inst (
        .clk200m  (clk200m),
        .rst      (rst),
        .bus      (kb_bus.slave),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data)
    );

    // top led mirrors the reset line
    assign leds = {rst, led};

endmodule

`default_nettype wire

// File: verif/periph_checker.sv
// checker for bus reads, leds, display clear line and serial frames of the peripheral top
`timescale 1ns/1ps
`default_nettype none

module periph_checker import soc_pkg::*; (
    input  wire logic              clk200m,
    input  wire logic              rst,
    input  wire logic              wb_we,
    input  wire logic [ADDR_W-1:0] wb_adr,
    input  wire logic [DATA_W-1:0] wb_dat_w,
    input  wire logic [DATA_W-1:0] wb_dat_r,
    input  wire logic              wb_ack,
    input  wire logic [7:0]        leds,
    input  wire logic              seg_clk,
    input  wire logic              seg_clr,
    input  wire logic              seg_dt,
    input  wire logic              seg_en,
    // expectations from the stimulus driver
    input  wire logic              exp_rd_en,
    input  wire logic [DATA_W-1:0] exp_rd_data,
    input  wire logic              frame_wait,
    input  wire logic [DATA_W-1:0] exp_frame,
    output      logic [31:0]       error_count,
    output      logic [31:0]       check_count,
    output      logic [31:0]       frame_hits
);

    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          hit_cnt = 0;
    int          bit_cnt = 0;
    logic        led_pend = 1'b0;
    logic [6:0]  led_exp;
    logic [31:0] seg_last = '0;
    logic [31:0] seg_prev = '0;
    logic [63:0] frame_sh;
    logic        seg_clk_d = 1'b0;
    logic        seg_en_d = 1'b0;
    logic        rst_d = 1'b1;

    // reference segment table, active low, dot off
    function automatic logic [7:0] seg_code(input logic [3:0] h);
        case (h)
            4'h0: return 8'hC0;
            4'h1: return 8'hF9;
            4'h2: return 8'hA4;
            4'h3: return 8'hB0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hF8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'hA: return 8'h88;
            4'hB: return 8'h83;
            4'hC: return 8'hC6;
            4'hD: return 8'hA1;
            4'hE: return 8'h86;
            default: return 8'h8E;
        endcase
    endfunction

    // most significant digit is shifted out first
    function automatic logic [63:0] frame_of(input logic [31:0] num);
        logic [63:0] f;
        f = '0;
        for (int d = 7; d >= 0; d--) begin
            f = {f[55:0], seg_code(num[d*4 +: 4])};
        end
        return f;
    endfunction

    task automatic check_frame();
        if (bit_cnt != 64) begin
            $display("[ERROR] %0t ns: display frame had %0d bits, expected 64", $time, bit_cnt);
            err_cnt++;
        end else if (frame_wait) begin
            if (frame_sh === frame_of(exp_frame)) begin
                chk_cnt++;
                hit_cnt++;
            end else if (frame_sh === frame_of(seg_prev)) begin
                // earlier number, overwritten while waiting
                $display("display frame for superseded number %08h skipped", seg_prev);
            end else begin
                $display("[ERROR] %0t ns: display frame %016h, expected %016h for %08h",
                         $time, frame_sh, frame_of(exp_frame), exp_frame);
                err_cnt++;
            end
        end else if (frame_sh !== frame_of(seg_last) && frame_sh !== frame_of(seg_prev)) begin
            $display("[ERROR] %0t ns: unexpected display frame %016h", $time, frame_sh);
            err_cnt++;
        end
    endtask

    always @(posedge clk200m) begin
        seg_clk_d <= seg_clk;
        seg_en_d  <= seg_en;
        rst_d     <= rst;
        // clear line low in reset, high from the first cycle after it
        if (seg_clr !== !(rst || rst_d)) begin
            $display("[ERROR] %0t ns: seg_clr is %b, expected %b",
                     $time, seg_clr, !(rst || rst_d));
            err_cnt++;
        end
        // top led is the reset tap
        if (leds[7] !== rst) begin
            $display("[ERROR] %0t ns: leds[7] is %b, expected %b", $time, leds[7], rst);
            err_cnt++;
        end
        if (!rst) begin
            // read data in the ack cycle
            if (wb_ack && !wb_we && exp_rd_en) begin
                chk_cnt++;
                if (wb_dat_r !== exp_rd_data) begin
                    $display("[ERROR] %0t ns: read of %02h returned %08h, expected %08h",
                             $time, wb_adr, wb_dat_r, exp_rd_data);
                    err_cnt++;
                end
            end
            // led pins one cycle after the write lands, top led follows reset
            if (led_pend) begin
                chk_cnt++;
                if (leds !== {1'b0, led_exp}) begin
                    $display("[ERROR] %0t ns: leds show %02h, expected %02h",
                             $time, leds, {1'b0, led_exp});
                    err_cnt++;
                end
            end
            led_pend <= wb_ack && wb_we && (wb_adr == ADDR_LED);
            led_exp  <= wb_dat_w[6:0];
            // last two display numbers seen on the bus
            if (wb_ack && wb_we && (wb_adr == ADDR_SEG)) begin
                seg_prev <= seg_last;
                seg_last <= wb_dat_w;
            end
            // receiver samples on the shift clock rising
            if (seg_clk && !seg_clk_d) begin
                frame_sh <= {frame_sh[62:0], seg_dt};
                bit_cnt++;
            end
            // enable rising marks a complete frame
            if (seg_en && !seg_en_d) begin
                check_frame();
                bit_cnt = 0;
            end
        end
    end

    assign error_count = err_cnt;
    assign check_count = chk_cnt;
    assign frame_hits  = hit_cnt;

endmodule

`default_nettype wire

// File: verif/tb_periph.sv
// testbench top with clock, reset, stimulus reader, bus and ps2 drivers and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_periph import soc_pkg::*; ();

    logic              clk200m;
    logic              rst;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADDR_W-1:0] wb_adr;
    logic [DATA_W-1:0] wb_dat_w;
    logic [DATA_W-1:0] wb_dat_r;
    logic              wb_ack;
    logic              ps2_clk;
    logic              ps2_data;
    logic [SWT_W-1:0]  swt;
    logic [7:0]        leds;
    logic              seg_clk;
    logic              seg_clr;
    logic              seg_dt;
    logic              seg_en;
    // expectations handed to the checker
    logic              exp_rd_en;
    logic [DATA_W-1:0] exp_rd_data;
    logic              frame_wait;
    logic [DATA_W-1:0] exp_frame;
    logic [31:0]       chk_errors;
    logic [31:0]       chk_checks;
    logic [31:0]       frame_hits;
    // parsed stimulus
    logic [7:0]        op_q[$];
    logic [31:0]       a_q[$];
    logic [31:0]       b_q[$];
    int                n_ops;
    int                tb_errors;
    logic              ops_loaded;
    logic [31:0]       lfsr;

    periph_top periph_top_inst (
        .clk200m (clk200m), .rst (rst),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
        .ps2_clk (ps2_clk), .ps2_data (ps2_data), .swt (swt), .leds (leds),
        .seg_clk (seg_clk), .seg_clr (seg_clr), .seg_dt (seg_dt), .seg_en (seg_en)
    );

    periph_checker periph_checker_inst (
        .clk200m (clk200m), .rst (rst),
        .wb_we (wb_we), .wb_adr (wb_adr), .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r), .wb_ack (wb_ack), .leds (leds),
        .seg_clk (seg_clk), .seg_clr (seg_clr), .seg_dt (seg_dt), .seg_en (seg_en),
        .exp_rd_en (exp_rd_en), .exp_rd_data (exp_rd_data),
        .frame_wait (frame_wait), .exp_frame (exp_frame),
        .error_count (chk_errors), .check_count (chk_checks), .frame_hits (frame_hits)
    );

    // 100 ns period
    initial begin
        clk200m = 1'b0;
        forever #50 clk200m = ~clk200m;
    end

    // galois form, taps x^32 x^22 x^2 x 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // inputs change 10 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk200m);
        #10;
    endtask

    // 0 to 3 idle cycles, one lfsr step per bit
    task automatic idle_gap();
        logic [1:0] gap;
        gap = '0;
        repeat (2) begin
            gap  = {gap[0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        repeat (gap) step_cycle();
    endtask

    task automatic bus_access(input logic we, input logic [7:0] adr, input logic [31:0] data);
        int   waited;
        logic got_ack;
        wb_cyc      = 1'b1;
        wb_stb      = 1'b1;
        wb_we       = we;
        wb_adr      = adr;
        wb_dat_w    = we ? data : '0;
        exp_rd_en   = !we;
        exp_rd_data = data;
        waited      = 0;
        got_ack     = 1'b0;
        while (!got_ack && waited < 16) begin
            step_cycle();
            got_ack = wb_ack;
            waited++;
        end
        if (got_ack) begin
            // hold the request through the ack edge
            step_cycle();
        end else begin
            $display("no ack from the bus within 16 cycles for address %02h", adr);
            tb_errors++;
        end
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        exp_rd_en = 1'b0;
        step_cycle();
        idle_gap();
    endtask

    // start, data lsb first, parity, stop, 8 cycles per half bit
    task automatic ps2_send(input logic [7:0] data, input logic good);
        logic [10:0] bits;
        bits = {1'b1, good ? ~^data : ^data, data, 1'b0};
        for (int k = 0; k < 11; k++) begin
            ps2_data = bits[k];
            repeat (8) step_cycle();
            ps2_clk = 1'b0;
            repeat (8) step_cycle();
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        repeat (8) step_cycle();
    endtask

    task automatic set_switches(input logic [7:0] value);
        swt = value;
        // past the two-flop synchronizer
        repeat (4) step_cycle();
    endtask

    task automatic wait_frame(input logic [31:0] num);
        int          waited;
        logic [31:0] hits0;
        exp_frame  = num;
        frame_wait = 1'b1;
        hits0      = frame_hits;
        waited     = 0;
        // room for one superseded frame plus the wanted one
        while (frame_hits == hits0 && waited < 1536) begin
            step_cycle();
            waited++;
        end
        if (frame_hits == hits0) begin
            $display("no display frame showing %08h arrived within %0d cycles", num, waited);
            tb_errors++;
        end
        frame_wait = 1'b0;
    endtask

    // longest operation is a frame of 512 cycles, doubled
    initial begin
        wait (ops_loaded);
        repeat (n_ops * 512 * 2) @(posedge clk200m);
        $display("watchdog expired after %0d cycles, the run did not finish", n_ops * 1024);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int               fd;
        int               code;
        int               errs_before;
        logic [7:0]       op;
        logic [31:0]      a;
        logic [31:0]      b;
        reg [8*96-1:0]    line;
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        swt = '0;
        exp_rd_en = 1'b0;
        exp_rd_data = '0;
        frame_wait = 1'b0;
        exp_frame = '0;
        tb_errors = 0;
        n_ops = 0;
        ops_loaded = 1'b0;
        lfsr = 32'he29f2a30;
        fd = $fopen("verif/periph_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file verif/periph_stimulus.txt");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            // comment lines start with #
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0) begin
                    code = $sscanf(line, " %c %h %h", op, a, b);
                    if (code == 3 && op != "#") begin
                        op_q.push_back(op);
                        a_q.push_back(a);
                        b_q.push_back(b);
                    end
                end
            end
            $fclose(fd);
            n_ops = op_q.size();
            ops_loaded = 1'b1;
            // reset held over three rising edges
            repeat (3) @(posedge clk200m);
            #10;
            rst = 1'b0;
            step_cycle();
            for (int i = 0; i < n_ops; i++) begin
                errs_before = chk_errors + tb_errors;
                case (op_q[i])
                    "W": bus_access(1'b1, a_q[i][7:0], b_q[i]);
                    "R": bus_access(1'b0, a_q[i][7:0], b_q[i]);
                    "K": ps2_send(a_q[i][7:0], b_q[i][0]);
                    "S": set_switches(a_q[i][7:0]);
                    "F": wait_frame(a_q[i]);
                    default: begin
                        $display("unknown operation %c in stimulus entry %0d", op_q[i], i);
                        tb_errors++;
                    end
                endcase
                $display("test %0d %c %h %h: %s", i, op_q[i], a_q[i], b_q[i],
                         (chk_errors + tb_errors == errs_before) ? "ok" : "mismatch");
            end
            $display("tests %0d, checks %0d, errors %0d", n_ops, chk_checks,
                     chk_errors + tb_errors);
            if (chk_errors + tb_errors == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: src.f
hdl/soc_pkg.sv
hdl/periph_bus_if.sv
hdl/periph_decoder.sv
hdl/gpio_regs.sv
hdl/seg_serial.sv
hdl/ps2_kbd_rx.sv
hdl/periph_top.sv
verif/periph_checker.sv
verif/tb_periph.sv

// File: Bender.yml
package:
  name: periph_soc

sources:
  # design, package and interface first
  - files:
      - hdl/soc_pkg.sv
      - hdl/periph_bus_if.sv
      - hdl/periph_decoder.sv
      - hdl/gpio_regs.sv
      - hdl/seg_serial.sv
      - hdl/ps2_kbd_rx.sv
      - hdl/periph_top.sv

  # simulation only
  - target: test
    files:
      - verif/periph_checker.sv
      - verif/tb_periph.sv

// File: verif/periph_stimulus.txt
# op addr data, hex. W write, R read with expected data, S switch value
# K byte with 1 for good parity, 0 for bad. F expected display number
R 00 00000000
W 00 0000005a
R 00 0000005a
W 00 000000ff
R 00 0000007f
S a5 0
R 04 000000a5
S 3c 0
R 04 0000003c
W 08 0123abcd
F 0123abcd 0
R 08 0123abcd
W 08 11111111
W 08 89effe98
F 89effe98 0
R 08 89effe98
K 1c 1
K 32 1
K f0 1
R 0c 0000011c
R 0c 00000132
R 0c 000001f0
R 0c 00000000
K 55 0
R 10 00000000
K 01 1
K 02 1
K 03 1
K 04 1
K 05 1
K 06 1
K 07 1
K 08 1
K 09 1
R 10 00000018
R 10 00000008
R 0c 00000101
R 0c 00000102
R 0c 00000103
R 0c 00000104
R 0c 00000105
R 0c 00000106
R 0c 00000107
R 0c 00000108
R 0c 00000000
R 20 00000000
W 14 00000000
R 00 0000007f
R 08 89effe98
